/* build.f */
common/uart_frame_pkg.sv
serial/uart_rx.sv
serial/uart_tx.sv
framer/frame_collector.sv
framer/frame_responder.sv
src/uart_link.sv
verification/tb_uart_link.sv

/* common/uart_frame_pkg.sv */
package uart_frame_pkg;

    // ======================================================================
    // Frame geometry
    // ======================================================================

    parameter int PAYLOAD_BYTES = 8;
    parameter int FRAME_BYTES = 4 + PAYLOAD_BYTES + 2; // Id, payload, checksum.

    typedef logic [PAYLOAD_BYTES*8-1:0] payload_t;

    // Field view of a frame, identifier at the top.
    typedef struct packed {
        logic [31:0] msgid;
        payload_t payload;
        logic [15:0] csum;
    } frame_fields_t;

    // The same 112-bit word is shifted as bytes and read as fields.
    typedef union packed {
        frame_fields_t f;
        logic [0:FRAME_BYTES-1][7:0] b; // Byte 0 sits at the MSB end.
    } frame_t;

    // ======================================================================
    // Byte transport
    // ======================================================================

    // Receiver output, valid is a one-cycle strobe.
    typedef struct packed {
        logic valid;
        logic [7:0] data;
    } rx_byte_t;

    // Responder to transmitter, four-phase req/ack.
    typedef struct packed {
        logic req;
        logic [7:0] data;
    } tx_req_t;

endpackage

/* framer/frame_collector.sv */
module frame_collector #(
    parameter logic [31:0] msgid = 32'h74697277,
    parameter bit csum_enable = 1'b1
) (
    input  logic clk,
    input  logic reset,
    input  uart_frame_pkg::rx_byte_t rx_byte,
    input  logic packet_end,
    output uart_frame_pkg::payload_t rx_data,
    output logic sync,
    output logic frame_drop,
    output logic accept
);

    localparam int frame_bytes = uart_frame_pkg::FRAME_BYTES;
    localparam int cnt_w = $clog2(frame_bytes + 2);
    localparam logic [cnt_w-1:0] overflow_mark = cnt_w'(frame_bytes + 1);

    uart_frame_pkg::frame_t frame;
    logic [cnt_w-1:0] byte_cnt;
    logic [15:0] sum;
    logic frame_ok;

    assign frame_ok = (byte_cnt == cnt_w'(frame_bytes)) &&
                      (frame.f.msgid == msgid) &&
                      (!csum_enable || frame.f.csum == sum);

    assign accept = sync;

    // ======================================================================
    // Byte collection
    // ======================================================================

    always_ff @(posedge clk) begin
        if (rx_byte.valid) frame.b <= {frame.b[1:frame_bytes-1], rx_byte.data};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            byte_cnt <= '0;
            sum <= '0;
        end else if (packet_end) begin
            byte_cnt <= '0;
            sum <= '0;
        end else if (rx_byte.valid) begin
            if (byte_cnt != overflow_mark) byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt < cnt_w'(frame_bytes - 2)) begin
                sum <= sum + 16'(rx_byte.data); // Checksum bytes excluded.
            end
        end
    end

    // ======================================================================
    // Decision
    // ======================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            sync <= 1'b0;
            frame_drop <= 1'b0;
        end else begin
            sync <= packet_end && frame_ok;
            frame_drop <= packet_end && !frame_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (packet_end && frame_ok) rx_data <= frame.f.payload;
    end

    no_byte_at_end: assert property (@(posedge clk) disable iff (reset)
        packet_end |-> !rx_byte.valid);

endmodule

/* framer/frame_responder.sv */
module frame_responder #(
    parameter logic [31:0] msgid = 32'h74697277
) (
    input  logic clk,
    input  logic reset,
    input  logic accept,
    input  uart_frame_pkg::payload_t tx_data,
    input  logic tx_ack,
    output uart_frame_pkg::tx_req_t tx_req,
    output logic tx_busy
);

    localparam int frame_bytes = uart_frame_pkg::FRAME_BYTES;
    localparam int idx_w = $clog2(frame_bytes + 1);

    uart_frame_pkg::frame_t reply;
    logic [idx_w-1:0] idx;
    logic [15:0] sum;
    logic req;
    logic [7:0] data;
    logic start;
    logic raise;
    logic handshake;

    assign start = accept && !tx_busy; // No second reply while busy.
    assign raise = tx_busy && !req && !tx_ack && (idx < idx_w'(frame_bytes));
    assign handshake = req && tx_ack;
    assign tx_req = '{req: req, data: data};

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_busy <= 1'b0;
            req <= 1'b0;
            idx <= '0;
        end else if (start) begin
            tx_busy <= 1'b1;
            idx <= '0;
        end else if (raise) begin
            req <= 1'b1;
        end else if (handshake) begin
            req <= 1'b0;
            idx <= idx + 1'b1;
        end else if (tx_busy && !tx_ack && idx == idx_w'(frame_bytes)) begin
            tx_busy <= 1'b0; // Last ack released.
        end
    end

    // ======================================================================
    // Reply frame and running checksum
    // ======================================================================

    always_ff @(posedge clk) begin
        if (start) begin
            reply.f <= '{msgid: msgid, payload: tx_data, csum: 16'h0000};
            sum <= '0;
        end else if (handshake && idx < idx_w'(frame_bytes - 2)) begin
            sum <= sum + 16'(data);
            if (idx == idx_w'(frame_bytes - 3)) reply.f.csum <= sum + 16'(data);
        end
    end

    always_ff @(posedge clk) begin
        if (raise) data <= reply.b[idx];
    end

    ack_falls_after_req: assert property (@(posedge clk) disable iff (reset)
        $fell(tx_ack) |-> !req);

endmodule

/* serial/uart_rx.sv */
module uart_rx #(
    parameter int clk_frequency = 25_000_000,
    parameter int baud = 2_500_000
) (
    input  logic clk,
    input  logic reset,
    input  logic rx,
    output uart_frame_pkg::rx_byte_t rx_byte,
    output logic packet_end
);

    localparam int bit_clocks = clk_frequency / baud;
    localparam int half_clocks = bit_clocks / 2;
    localparam int gap_clocks = 20 * bit_clocks + half_clocks; // From mid stop bit.
    localparam int bit_w = $clog2(bit_clocks + 1);
    localparam int gap_w = $clog2(gap_clocks + 1);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_start = 2'd1;
    localparam logic [1:0] st_data = 2'd2;
    localparam logic [1:0] st_stop = 2'd3;

    logic rx_meta;
    logic rx_sync;
    logic [1:0] state;
    logic [bit_w-1:0] clk_cnt;
    logic [2:0] bit_idx;
    logic [7:0] shift;
    logic byte_valid;
    logic bit_tick;
    logic gap_armed;
    logic [gap_w-1:0] gap_cnt;

    assign bit_tick = (clk_cnt == bit_w'(bit_clocks - 1));
    assign rx_byte = '{valid: byte_valid, data: shift};

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // ======================================================================
    // Bit sampling
    // ======================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            clk_cnt <= '0;
            bit_idx <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                st_idle: begin
                    clk_cnt <= '0;
                    if (!rx_sync) state <= st_start;
                end
                st_start: begin
                    if (clk_cnt == bit_w'(half_clocks - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state <= rx_sync ? st_idle : st_data; // Glitch, not a start bit.
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= st_stop;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_tick) begin
                        byte_valid <= rx_sync; // Framing error drops the byte.
                        state <= st_idle;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_data && bit_tick) shift <= {rx_sync, shift[7:1]}; // LSB first.
    end

    // Idle gap after the last byte ends the frame.
    always_ff @(posedge clk) begin
        if (reset) begin
            gap_armed <= 1'b0;
            gap_cnt <= '0;
            packet_end <= 1'b0;
        end else begin
            packet_end <= 1'b0;
            if (byte_valid) begin
                gap_armed <= 1'b1;
                gap_cnt <= '0;
            end else if (state != st_idle) begin
                gap_cnt <= '0;
            end else if (gap_armed) begin
                if (gap_cnt == gap_w'(gap_clocks - 1)) begin
                    packet_end <= 1'b1;
                    gap_armed <= 1'b0;
                end else begin
                    gap_cnt <= gap_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* serial/uart_tx.sv */
module uart_tx #(
    parameter int clk_frequency = 25_000_000,
    parameter int baud = 2_500_000
) (
    input  logic clk,
    input  logic reset,
    input  uart_frame_pkg::tx_req_t tx_req,
    output logic tx_ack,
    output logic tx
);

    localparam int bit_clocks = clk_frequency / baud;
    localparam int bit_w = $clog2(bit_clocks + 1);

    logic busy;
    logic load;
    logic bit_done;
    logic [bit_w-1:0] clk_cnt;
    logic [3:0] bits_left;
    logic [9:0] frame_bits; // Stop, data, start.

    assign load = tx_req.req && !tx_ack && !busy;
    assign bit_done = busy && (clk_cnt == bit_w'(bit_clocks - 1));
    assign tx = busy ? frame_bits[0] : 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            tx_ack <= 1'b0;
            clk_cnt <= '0;
            bits_left <= '0;
        end else if (load) begin
            busy <= 1'b1;
            tx_ack <= 1'b1;
            clk_cnt <= '0;
            bits_left <= 4'd10;
        end else if (busy) begin
            if (bit_done) begin
                clk_cnt <= '0;
                bits_left <= bits_left - 1'b1;
                if (bits_left == 4'd1) busy <= 1'b0; // Stop bit done.
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end else if (!tx_req.req) begin
            tx_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            frame_bits <= {1'b1, tx_req.data, 1'b0};
        end else if (bit_done) begin
            frame_bits <= {1'b1, frame_bits[9:1]};
        end
    end

    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(tx_ack) |-> tx_req.req);

endmodule

/* src/uart_link.sv */
module uart_link #(
    parameter int clk_frequency = 25_000_000,
    parameter int baud = 2_500_000,
    parameter logic [31:0] msgid = 32'h74697277,
    parameter bit csum_enable = 1'b1
) (
    input  logic clk,
    input  logic reset,
    input  logic rx,
    input  uart_frame_pkg::payload_t tx_data,
    output logic tx,
    output uart_frame_pkg::payload_t rx_data,
    output logic sync,
    output logic frame_drop,
    output logic tx_busy
);

    uart_frame_pkg::rx_byte_t rx_byte;
    uart_frame_pkg::tx_req_t tx_req;
    logic packet_end;
    logic accept;
    logic tx_ack;

    uart_rx #(.clk_frequency(clk_frequency), .baud(baud)) i_uart_rx (
        .clk        (clk),
        .reset      (reset),
        .rx         (rx),
        .rx_byte    (rx_byte),
        .packet_end (packet_end)
    );

    frame_collector #(.msgid(msgid), .csum_enable(csum_enable)) i_frame_collector (
        .clk        (clk),
        .reset      (reset),
        .rx_byte    (rx_byte),
        .packet_end (packet_end),
        .rx_data    (rx_data),
        .sync       (sync),
        .frame_drop (frame_drop),
        .accept     (accept)
    );

    frame_responder #(.msgid(msgid)) i_frame_responder (
        .clk     (clk),
        .reset   (reset),
        .accept  (accept),
        .tx_data (tx_data),
        .tx_ack  (tx_ack),
        .tx_req  (tx_req),
        .tx_busy (tx_busy)
    );

    uart_tx #(.clk_frequency(clk_frequency), .baud(baud)) i_uart_tx (
        .clk    (clk),
        .reset  (reset),
        .tx_req (tx_req),
        .tx_ack (tx_ack),
        .tx     (tx)
    );

endmodule

/* verification/tb_uart_link.sv */
module tb_uart_link;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] default_msgid = 32'h74697277;
    localparam int frame_bytes = uart_frame_pkg::FRAME_BYTES;
    localparam int bit_clocks = 10;
    localparam int frame_count = 27; // 1 valid, 4 dropped, 2 overlapping, 20 random.
    localparam int cycle_limit = frame_count * 3 * frame_bytes * 10 * bit_clocks + 5000;
    localparam int quiet_cycles = 300;

    logic clk;
    logic reset;
    logic rx;
    uart_frame_pkg::payload_t tx_data;
    logic tx;
    uart_frame_pkg::payload_t rx_data;
    logic sync;
    logic frame_drop;
    logic tx_busy;

    int errors = 0;
    int sync_count = 0;
    int drop_count = 0;
    int tx_byte_count = 0;
    int frames_sent = 0;
    int expected_replies = 0;
    int checked_replies = 0;
    int cycle_count = 0;
    int seed_value;
    int bit_pos;
    int reply_fill = 0;
    int i;
    string current_test = "reset";
    logic reply_active = 1'b0;
    logic [7:0] line_byte;
    logic [111:0] reply_word;
    logic [111:0] got_frame;
    logic [111:0] want_frame;
    logic [111:0] work_frame;
    logic [63:0] want_payload;
    logic [63:0] last_rx_data;
    logic [7:0] frame_buf [0:frame_bytes];
    logic [63:0] exp_rx [$];
    logic [111:0] exp_reply [$];
    logic [111:0] got_reply [$];

    uart_link #(
        .clk_frequency (25_000_000),
        .baud          (2_500_000),
        .csum_enable   (1'b1)
    ) i_uart_link (
        .clk        (clk),
        .reset      (reset),
        .rx         (rx),
        .tx_data    (tx_data),
        .tx         (tx),
        .rx_data    (rx_data),
        .sync       (sync),
        .frame_drop (frame_drop),
        .tx_busy    (tx_busy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles in test %s", cycle_count, current_test);
            $display("** FAIL **");
            $finish;
        end
    end

    // ======================================================================
    // Reference model and stimulus helpers
    // ======================================================================

    // Id, payload, then the sum of the first 12 bytes.
    function automatic logic [111:0] ref_frame(input logic [31:0] id, input logic [63:0] payload);
        logic [111:0] f;
        logic [15:0] sum;
        int k;
        f = {id, payload, 16'h0000};
        sum = '0;
        for (k = 0; k < frame_bytes - 2; k++) begin
            sum = sum + 16'(f[111 - 8*k -: 8]);
        end
        f[15:0] = sum;
        return f;
    endfunction

    function automatic logic [63:0] random_payload();
        return {$urandom, $urandom};
    endfunction

    task automatic load_frame(input logic [111:0] f);
        int k;
        for (k = 0; k < frame_bytes; k++) begin
            frame_buf[k] = f[111 - 8*k -: 8];
        end
        frame_buf[frame_bytes] = 8'($urandom); // Extra byte for the long frame.
    endtask

    // 8N1, LSB first, 10 clocks per bit.
    task automatic send_frame(input int n);
        logic [9:0] bits;
        int b;
        int k;
        @(posedge clk);
        for (b = 0; b < n; b++) begin
            bits = {1'b1, frame_buf[b], 1'b0};
            for (k = 0; k < 10; k++) begin
                rx <= bits[k];
                repeat (bit_clocks) @(posedge clk);
            end
        end
        frames_sent++;
    endtask

    task automatic compare_count(input string name, input string what,
                                 input int expected, input int actual);
        if (actual != expected) begin
            $display("** Error [%s] %s: expected %0d, actual %0d",
                     name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic run_frame(input string name, input logic [111:0] f,
                             input int n, input bit good);
        int s0;
        int d0;
        int b0;
        s0 = sync_count;
        d0 = drop_count;
        b0 = tx_byte_count;
        current_test = name;
        load_frame(f);
        if (good) exp_rx.push_back(f[79:16]);
        send_frame(n);
        wait (sync_count != s0 || drop_count != d0);
        wait (checked_replies == expected_replies && !tx_busy);
        repeat (quiet_cycles) @(posedge clk);
        compare_count(name, "sync pulses", good ? 1 : 0, sync_count - s0);
        compare_count(name, "frame_drop pulses", good ? 0 : 1, drop_count - d0);
        compare_count(name, "reply bytes", good ? frame_bytes : 0, tx_byte_count - b0);
    endtask

    // Second frame arrives while the first reply is on the line.
    task automatic run_overlap();
        logic [111:0] first;
        logic [111:0] second;
        int s0;
        int d0;
        int b0;
        int r0;
        s0 = sync_count;
        d0 = drop_count;
        b0 = tx_byte_count;
        r0 = expected_replies;
        current_test = "overlap";
        first = ref_frame(default_msgid, random_payload());
        second = ref_frame(default_msgid, random_payload());
        @(posedge clk);
        tx_data <= random_payload();
        load_frame(first);
        exp_rx.push_back(first[79:16]);
        send_frame(frame_bytes);
        wait (sync_count != s0);
        @(posedge clk);
        tx_data <= random_payload(); // Reply in progress keeps the captured data.
        load_frame(second);
        exp_rx.push_back(second[79:16]);
        @(negedge clk);
        if (tx_busy !== 1'b1) begin
            $display("tx_busy was not high when the overlapping frame started");
            errors++;
        end
        send_frame(frame_bytes);
        wait (sync_count == s0 + 2 || drop_count != d0);
        wait (checked_replies == expected_replies && !tx_busy);
        repeat (quiet_cycles) @(posedge clk);
        compare_count("overlap", "sync pulses", 2, sync_count - s0);
        compare_count("overlap", "frame_drop pulses", 0, drop_count - d0);
        compare_count("overlap", "reply bytes", frame_bytes * (expected_replies - r0),
                      tx_byte_count - b0);
    endtask

    // ======================================================================
    // Line monitor and comparing process
    // ======================================================================

    initial begin
        forever begin
            @(negedge clk);
            if (!reset && tx === 1'b0) begin
                repeat (4) @(negedge clk); // Middle of the start bit.
                if (tx !== 1'b0) begin
                    $display("Start bit on tx ended early in test %s", current_test);
                    errors++;
                end
                for (bit_pos = 0; bit_pos < 8; bit_pos++) begin
                    repeat (bit_clocks) @(negedge clk);
                    line_byte[bit_pos] = tx;
                end
                repeat (bit_clocks) @(negedge clk);
                if (tx !== 1'b1) begin
                    $display("Stop bit missing on tx in test %s", current_test);
                    errors++;
                end
                tx_byte_count++;
                reply_word = {reply_word[103:0], line_byte};
                reply_fill++;
                if (reply_fill == frame_bytes) begin
                    got_reply.push_back(reply_word);
                    reply_fill = 0;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            if (sync) begin
                if (exp_rx.size() == 0) begin
                    $display("Sync pulsed with no valid frame sent in test %s", current_test);
                    errors++;
                end else begin
                    want_payload = exp_rx.pop_front();
                    if (rx_data !== want_payload) begin
                        $display("** Error [%s] rx_data: expected %h, actual %h",
                                 current_test, want_payload, rx_data);
                        errors++;
                    end
                    last_rx_data = want_payload;
                end
                if (!reply_active) begin // Accept while idle starts a reply.
                    exp_reply.push_back(ref_frame(default_msgid, tx_data));
                    expected_replies++;
                    reply_active = 1'b1;
                end
                sync_count++;
            end
            if (frame_drop) begin
                if (rx_data !== last_rx_data) begin
                    $display("** Error [%s] rx_data after drop: expected %h, actual %h",
                             current_test, last_rx_data, rx_data);
                    errors++;
                end
                drop_count++;
            end
            if (got_reply.size() != 0) begin
                got_frame = got_reply.pop_front();
                reply_active = 1'b0;
                if (exp_reply.size() == 0) begin
                    $display("Reply on tx with no accepted frame in test %s", current_test);
                    errors++;
                end else begin
                    want_frame = exp_reply.pop_front();
                    if (got_frame !== want_frame) begin
                        $display("** Error [%s] reply: expected %h, actual %h",
                                 current_test, want_frame, got_frame);
                        errors++;
                    end
                    checked_replies++;
                end
            end
        end
    end

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin
        seed_value = $urandom(52668);
        reset = 1'b1;
        rx = 1'b1;
        tx_data = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (sync !== 1'b0 || frame_drop !== 1'b0 || tx_busy !== 1'b0 || tx !== 1'b1) begin
            $display("Outputs not idle after reset");
            errors++;
        end

        @(posedge clk);
        tx_data <= random_payload();
        run_frame("valid_frame", ref_frame(default_msgid, random_payload()), 14, 1'b1);

        work_frame = ref_frame(default_msgid, random_payload());
        work_frame[15:0] = work_frame[15:0] ^ 16'h0001;
        run_frame("bad_checksum", work_frame, 14, 1'b0);
        run_frame("bad_msgid", ref_frame(default_msgid ^ 32'h0000_0100, random_payload()),
                  14, 1'b0);
        run_frame("short_frame", ref_frame(default_msgid, random_payload()), 13, 1'b0);
        run_frame("long_frame", ref_frame(default_msgid, random_payload()), 15, 1'b0);

        run_overlap();

        for (i = 0; i < 20; i++) begin
            @(posedge clk);
            tx_data <= random_payload();
            run_frame($sformatf("random_frame_%0d", i),
                      ref_frame(default_msgid, random_payload()), 14, 1'b1);
        end

        if (exp_rx.size() != 0) begin
            $display("%0d valid frames never produced a sync", exp_rx.size());
            errors++;
        end
        if (reply_fill != 0 || exp_reply.size() != 0) begin
            $display("A reply on tx was left unfinished");
            errors++;
        end
        $display("Frames sent: %0d, replies checked: %0d, errors: %0d",
                 frames_sent, checked_replies, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
